// File: verif/l1_cache_patterns.txt
// op addr mask wdata expect; op 1 read, 2 write, 3 L2 read count, 4 L2 write count, 0 end.
// L2 starts with every word equal to the complement of its byte address.
1 0000 3 0000 ffff  // Cold miss after reset.
3 0000 0 0000 0001
1 0006 3 0000 fff9  // Hit in the same line.
3 0000 0 0000 0001
2 0012 1 1234 0000  // Low byte only.
1 0012 3 0000 ff34
2 0012 2 ab00 0000  // High byte only.
1 0012 3 0000 ab34
2 0014 3 5a5a 0000  // Both bytes.
1 0014 3 0000 5a5a
1 0016 3 0000 ffe9
3 0000 0 0000 0002
1 0020 3 0000 ffdf  // Line A in set 2.
1 00a0 3 0000 ff5f  // Line B in set 2.
1 0022 3 0000 ffdd  // A again, B becomes LRU.
3 0000 0 0000 0004
1 0120 3 0000 fedf  // Line C evicts B.
3 0000 0 0000 0005
1 0024 3 0000 ffdb
3 0000 0 0000 0005
1 00a2 3 0000 ff5d
3 0000 0 0000 0006
2 0032 3 c0de 0000  // Dirty line X in set 3.
4 0000 0 0000 0000
1 00b0 3 0000 ff4f
1 0130 3 0000 fecf  // Evicts X with a writeback.
4 0000 0 0000 0001
3 0000 0 0000 0009
1 0032 3 0000 c0de  // X comes back from L2.
1 0030 3 0000 ffcf
3 0000 0 0000 000a
1 0090 3 0000 ff6f
1 0110 3 0000 feef  // Evicts the merged line of set 1.
4 0000 0 0000 0002
1 0012 3 0000 ab34
1 0014 3 0000 5a5a
3 0000 0 0000 000d
0 0000 0 0000 0000

// File: files.f
src/lc3b_types.sv
src/l1_way.sv
src/l1_cache_writelogic.sv
src/l1_cache_datapath.sv
src/l1_cache_control.sv
src/l1_cache.sv
verif/l1_cache_tb.sv

// File: Makefile
# Verilator simulation of the L1 cache testbench.

VERILATOR ?= verilator
TOP       ?= l1_cache_tb
FLAGS     ?= --timing --assert

.PHONY: sim clean

# The run passes only when the pass message shows up in the output.
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f files.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir

// File: verif/l1_cache_tb.sv
`default_nettype none
`timescale 1ns/1ps

module l1_cache_tb;

// ======================================================================
// Constants
// ======================================================================
localparam int CLK_PERIOD    = 40;
localparam int DRIVE_DELAY   = 2;
localparam int RESET_CYCLES  = 3;
localparam int L2_LATENCY    = 3;    // Cycles from request to l2_resp.
localparam int FIELDS        = 5;    // Words per pattern entry.
localparam int PATTERN_WORDS = 256;
localparam int MAX_ENTRIES   = PATTERN_WORDS / FIELDS;
localparam int WORST_CYCLES  = 16;   // Writeback plus fetch plus checks, with margin.

localparam logic [15:0] OP_END    = 16'h0;
localparam logic [15:0] OP_READ   = 16'h1;
localparam logic [15:0] OP_WRITE  = 16'h2;
localparam logic [15:0] OP_READS  = 16'h3;   // Expected number of L2 reads.
localparam logic [15:0] OP_WRITES = 16'h4;   // Expected number of L2 writes.

logic                      clk;
logic                      rst;
logic                      mem_read, mem_write;
lc3b_types::lc3b_mem_wmask mem_byte_enable;
lc3b_types::lc3b_word      mem_address, mem_wdata, mem_rdata;
logic                      mem_resp;
logic                      l2_resp;
lc3b_types::lc3b_cacheline l2_rdata, l2_wdata;
logic                      l2_read, l2_write;
lc3b_types::lc3b_word      l2_address;

logic [15:0] pattern_mem [PATTERN_WORDS];
logic [15:0] l2_mem [32768];              // 64 KB of 16-bit words.
int          l2_reads, l2_writes, l2_wait;
int          cycles, cycle_limit, num_entries;

l1_cache DUT
(
    .clk, .rst,
    .mem_read, .mem_write, .mem_byte_enable, .mem_address, .mem_wdata,
    .mem_resp, .mem_rdata,
    .l2_resp, .l2_rdata, .l2_read, .l2_write, .l2_address, .l2_wdata
);

always #(CLK_PERIOD / 2) clk = ~clk;

// ======================================================================
// Timeout
// ======================================================================
always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
        $display("Timeout: the cache stopped responding after %0d cycles.", cycles);
        $display("ERRORS FOUND");
        $fatal(1, "Run ended by the cycle limit.");
    end
end

// ======================================================================
// L2 memory model
// ======================================================================
function automatic lc3b_types::lc3b_cacheline read_line(input lc3b_types::lc3b_word addr);
    lc3b_types::lc3b_cacheline line;
    logic [14:0]               widx;
    for (int k = 0; k < 8; k++) begin
        widx = {addr[15:4], 3'(k)};
        line[16*k +: 16] = l2_mem[widx];
    end
    return line;
endfunction

task automatic store_line(input lc3b_types::lc3b_word addr,
                          input lc3b_types::lc3b_cacheline line);
    logic [14:0] widx;
    for (int k = 0; k < 8; k++) begin
        widx = {addr[15:4], 3'(k)};
        l2_mem[widx] = line[16*k +: 16];
    end
endtask

// Each request is answered once it has been seen for three cycles.
always begin
    @(posedge clk);
    #DRIVE_DELAY;
    if (rst || l2_resp) begin
        l2_resp = 1'b0;
        l2_wait = 0;
    end else if (l2_read || l2_write) begin
        l2_wait = l2_wait + 1;
        if (l2_wait == L2_LATENCY) begin
            l2_resp = 1'b1;
            if (l2_read) begin
                l2_rdata = read_line(l2_address);
                l2_reads = l2_reads + 1;
            end else begin
                store_line(l2_address, l2_wdata);
                l2_writes = l2_writes + 1;
            end
        end
    end
end

// ======================================================================
// Checks and CPU requests
// ======================================================================
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        $display("Fail %s: expected %h, actual %h", name, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1, "Value check failed.");
    end
endtask

// Holds one request until mem_resp, sampling mid-cycle where outputs are settled.
task automatic run_request(input logic write, input lc3b_types::lc3b_word addr,
                           input lc3b_types::lc3b_mem_wmask mask,
                           input lc3b_types::lc3b_word wdata,
                           output lc3b_types::lc3b_word rdata);
    mem_read        = ~write;
    mem_write       = write;
    mem_address     = addr;
    mem_byte_enable = mask;
    mem_wdata       = wdata;
    @(negedge clk);
    while (!mem_resp)
        @(negedge clk);
    rdata = mem_rdata;
    @(posedge clk);
    #DRIVE_DELAY;
    mem_read  = 1'b0;
    mem_write = 1'b0;
endtask

initial begin : main
    string                name;
    lc3b_types::lc3b_word rdata;
    logic [15:0]          op, addr, mask, wdata, expected;
    logic [7:0]           pidx;

    clk             = 1'b0;
    rst             = 1'b1;
    mem_read        = 1'b0;
    mem_write       = 1'b0;
    mem_byte_enable = '0;
    mem_address     = '0;
    mem_wdata       = '0;
    l2_resp         = 1'b0;
    l2_rdata        = '0;
    l2_reads        = 0;
    l2_writes       = 0;
    l2_wait         = 0;
    cycles          = 0;

    for (int a = 0; a < 32768; a++)
        l2_mem[15'(a)] = ~lc3b_types::lc3b_word'(2 * a);   // Complement of the byte address.
    for (int w = 0; w < PATTERN_WORDS; w++)
        pattern_mem[8'(w)] = OP_END;
    $readmemh("verif/l1_cache_patterns.txt", pattern_mem);

    num_entries = 0;
    while (num_entries < MAX_ENTRIES && pattern_mem[8'(num_entries * FIELDS)] != OP_END)
        num_entries = num_entries + 1;
    cycle_limit = num_entries * WORST_CYCLES + 50;
    if (num_entries == 0) begin
        $display("The pattern file holds no requests.");
        $display("ERRORS FOUND");
        $fatal(1, "Empty pattern file.");
    end

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    // Idle outputs right after reset.
    @(negedge clk);
    check_value("reset mem_resp", 32'h0, {31'b0, mem_resp});
    check_value("reset l2_read", 32'h0, {31'b0, l2_read});
    check_value("reset l2_write", 32'h0, {31'b0, l2_write});
    @(posedge clk);
    #DRIVE_DELAY;

    for (int e = 0; e < num_entries; e++) begin
        pidx     = 8'(e * FIELDS);
        op       = pattern_mem[pidx];
        addr     = pattern_mem[pidx + 8'd1];
        mask     = pattern_mem[pidx + 8'd2];
        wdata    = pattern_mem[pidx + 8'd3];
        expected = pattern_mem[pidx + 8'd4];
        case (op)
            OP_READ: begin
                name = $sformatf("read %h (entry %0d)", addr, e);
                run_request(1'b0, addr, mask[1:0], wdata, rdata);
                check_value(name, {16'h0, expected}, {16'h0, rdata});
            end
            OP_WRITE: begin
                run_request(1'b1, addr, mask[1:0], wdata, rdata);
            end
            OP_READS: begin
                name = $sformatf("L2 read count (entry %0d)", e);
                check_value(name, {16'h0, expected}, l2_reads);
            end
            OP_WRITES: begin
                name = $sformatf("L2 write count (entry %0d)", e);
                check_value(name, {16'h0, expected}, l2_writes);
            end
            default: begin
                $display("Pattern entry %0d has an unknown opcode %h.", e, op);
                $display("ERRORS FOUND");
                $fatal(1, "Bad pattern file.");
            end
        endcase
    end

    $display("NO ERRORS");
    $finish;
end

endmodule : l1_cache_tb

`default_nettype wire

// File: src/l1_cache.sv
`default_nettype none
`timescale 1ns/1ps

module l1_cache
(
    input  wire logic clk,
    input  wire logic rst,

    // CPU side.
    input  wire logic mem_read, mem_write,
    input  lc3b_types::lc3b_mem_wmask mem_byte_enable,
    input  lc3b_types::lc3b_word      mem_address, mem_wdata,
    output logic                      mem_resp,
    output lc3b_types::lc3b_word      mem_rdata,

    // L2 side.
    input  wire logic                 l2_resp,
    input  lc3b_types::lc3b_cacheline l2_rdata,
    output logic                      l2_read, l2_write,
    output lc3b_types::lc3b_word      l2_address,
    output lc3b_types::lc3b_cacheline l2_wdata
);

logic load_lru, lru_in, l2wdata_sel;
logic load_d0, load_v0, load_td0, d_in0, v_in0;
logic load_d1, load_v1, load_td1, d_in1, v_in1;
logic lru_out, d_out0, d_out1, hit0, hit1;
lc3b_types::l1_l2addr_src l2addr_sel;

l1_cache_control control
(
    .clk, .rst,
    .mem_read, .mem_write, .mem_resp,
    .hit0, .hit1, .lru_out, .d_out0, .d_out1,
    .l2_resp, .l2_read, .l2_write,
    .load_lru, .lru_in, .l2wdata_sel,
    .load_d0, .load_v0, .load_td0, .d_in0, .v_in0,
    .load_d1, .load_v1, .load_td1, .d_in1, .v_in1,
    .l2addr_sel
);

l1_cache_datapath datapath
(
    .clk, .rst,
    .load_lru, .lru_in, .l2wdata_sel,
    .load_d0, .load_v0, .load_td0, .d_in0, .v_in0,
    .load_d1, .load_v1, .load_td1, .d_in1, .v_in1,
    .l2addr_sel,
    .lru_out, .d_out0, .d_out1, .hit0, .hit1,
    .mem_byte_enable, .mem_address, .mem_wdata, .mem_rdata,
    .l2_read, .l2_rdata, .l2_address, .l2_wdata
);

endmodule : l1_cache

`default_nettype wire

// File: src/l1_cache_control.sv
`default_nettype none
`timescale 1ns/1ps

module l1_cache_control
(
    input  wire logic clk,
    input  wire logic rst,

    // CPU handshake.
    input  wire logic mem_read, mem_write,
    output logic mem_resp,

    // Datapath status.
    input  wire logic hit0, hit1, lru_out, d_out0, d_out1,

    // L2 handshake.
    input  wire logic l2_resp,
    output logic l2_read, l2_write,

    // Datapath control.
    output logic load_lru, lru_in, l2wdata_sel,
    output logic load_d0, load_v0, load_td0, d_in0, v_in0,
    output logic load_d1, load_v1, load_td1, d_in1, v_in1,
    output lc3b_types::l1_l2addr_src l2addr_sel
);

lc3b_types::l1_state state, next_state;
logic                request;
logic                hit;
logic                victim_dirty;

assign request      = mem_read | mem_write;
assign hit          = hit0 | hit1;
assign victim_dirty = lru_out ? d_out1 : d_out0;

always_ff @(posedge clk) begin
    if (rst)
        state <= lc3b_types::s_check;
    else
        state <= next_state;
end

// ======================================================================
// Next state and outputs
// ======================================================================
always_comb begin
    next_state  = state;
    mem_resp    = 1'b0;
    l2_read     = 1'b0;
    l2_write    = 1'b0;
    load_lru    = 1'b0;
    lru_in      = 1'b0;
    l2wdata_sel = lru_out;             // Victim way unless a hit overrides.
    l2addr_sel  = lc3b_types::addr_cpu;
    load_d0 = 1'b0; load_v0 = 1'b0; load_td0 = 1'b0; d_in0 = 1'b0; v_in0 = 1'b0;
    load_d1 = 1'b0; load_v1 = 1'b0; load_td1 = 1'b0; d_in1 = 1'b0; v_in1 = 1'b0;

    case (state)
        lc3b_types::s_check: begin
            if (request && hit) begin
                mem_resp    = 1'b1;
                l2wdata_sel = hit1;
                load_lru    = 1'b1;
                lru_in      = hit0;    // The other way becomes LRU.
                if (mem_write) begin
                    load_td0 = hit0;
                    load_d0  = hit0;
                    d_in0    = 1'b1;
                    load_td1 = hit1;
                    load_d1  = hit1;
                    d_in1    = 1'b1;
                end
            end else if (request) begin
                if (victim_dirty)
                    next_state = lc3b_types::s_writeback;
                else
                    next_state = lc3b_types::s_fetch;
            end
        end

        lc3b_types::s_writeback: begin
            l2_write = 1'b1;
            if (lru_out)
                l2addr_sel = lc3b_types::addr_way1;
            else
                l2addr_sel = lc3b_types::addr_way0;
            if (l2_resp)
                next_state = lc3b_types::s_fetch;
        end

        lc3b_types::s_fetch: begin
            l2_read = 1'b1;
            if (l2_resp) begin
                // Fill the victim way clean and valid.
                load_td0 = ~lru_out;
                load_v0  = ~lru_out;
                load_d0  = ~lru_out;
                v_in0    = 1'b1;
                load_td1 = lru_out;
                load_v1  = lru_out;
                load_d1  = lru_out;
                v_in1    = 1'b1;
                next_state = lc3b_types::s_check;
            end
        end

        default: next_state = lc3b_types::s_check;
    endcase
end

// The L2 sees one request at a time.
l2_one_req: assert property (@(posedge clk) disable iff (rst) !(l2_read && l2_write));

resp_needs_req: assert property (@(posedge clk) disable iff (rst)
    mem_resp |-> (mem_read || mem_write));

// A tag may live in only one way of a set.
hit_one_way: assert property (@(posedge clk) disable iff (rst) !(hit0 && hit1));

endmodule : l1_cache_control

`default_nettype wire

// File: src/l1_cache_datapath.sv
`default_nettype none
`timescale 1ns/1ps

module l1_cache_datapath
(
    input  wire logic clk,
    input  wire logic rst,

    // Control signals.
    input  wire logic load_lru, lru_in, l2wdata_sel,
    input  wire logic load_d0, load_v0, load_td0, d_in0, v_in0,
    input  wire logic load_d1, load_v1, load_td1, d_in1, v_in1,
    input  lc3b_types::l1_l2addr_src l2addr_sel,
    output logic lru_out, d_out0, d_out1, hit0, hit1,

    // CPU signals.
    input  lc3b_types::lc3b_mem_wmask mem_byte_enable,
    input  lc3b_types::lc3b_word      mem_address, mem_wdata,
    output lc3b_types::lc3b_word      mem_rdata,

    // L2 signals.
    input  wire logic l2_read,
    input  lc3b_types::lc3b_cacheline l2_rdata,
    output lc3b_types::lc3b_word      l2_address,
    output lc3b_types::lc3b_cacheline l2_wdata
);

lc3b_types::lc3b_c_tag     tag;
lc3b_types::lc3b_c_index   index;
lc3b_types::lc3b_c_offset  offset;
lc3b_types::lc3b_cacheline writelogic_out;
lc3b_types::lc3b_cacheline way_data [lc3b_types::L1_WAYS];
lc3b_types::lc3b_c_tag     way_tag  [lc3b_types::L1_WAYS];
logic                      v_out0, v_out1;
logic                      lru_bits [lc3b_types::L1_SETS];

assign tag    = mem_address[15:7];
assign index  = mem_address[6:4];
assign offset = mem_address[3:1];

// ======================================================================
// LRU bits, one per set, naming the way to replace next
// ======================================================================
always_ff @(posedge clk) begin
    if (rst) begin
        for (int s = 0; s < lc3b_types::L1_SETS; s++)
            lru_bits[s] <= 1'b0;
    end else if (load_lru) begin
        lru_bits[index] <= lru_in;
    end
end

assign lru_out = lru_bits[index];

// ======================================================================
// Ways and line merge
// ======================================================================
l1_cache_writelogic writelogic
(
    .l2_read, .mem_byte_enable, .offset, .mem_wdata, .l2_rdata,
    .cur_cacheline(l2_wdata), .output_cacheline(writelogic_out)
);

l1_way way0
(
    .clk, .rst,
    .load_d(load_d0), .load_v(load_v0), .load_td(load_td0), .index,
    .d_in(d_in0), .v_in(v_in0), .tag_in(tag), .data_in(writelogic_out),
    .d_out(d_out0), .v_out(v_out0), .tag_out(way_tag[0]), .data_out(way_data[0])
);

l1_way way1
(
    .clk, .rst,
    .load_d(load_d1), .load_v(load_v1), .load_td(load_td1), .index,
    .d_in(d_in1), .v_in(v_in1), .tag_in(tag), .data_in(writelogic_out),
    .d_out(d_out1), .v_out(v_out1), .tag_out(way_tag[1]), .data_out(way_data[1])
);

assign hit0 = v_out0 & (tag == way_tag[0]);
assign hit1 = v_out1 & (tag == way_tag[1]);

// ======================================================================
// Output selection
// ======================================================================
assign l2_wdata  = way_data[l2wdata_sel];            // Victim or hit line.
assign mem_rdata = l2_wdata[16*offset +: 16];

always_comb begin
    case (l2addr_sel)
        lc3b_types::addr_cpu:  l2_address = {mem_address[15:4], 4'h0};
        lc3b_types::addr_way0: l2_address = {way_tag[0], index, 4'h0};
        lc3b_types::addr_way1: l2_address = {way_tag[1], index, 4'h0};
        default:               l2_address = '0;
    endcase
end

endmodule : l1_cache_datapath

`default_nettype wire

// File: src/l1_cache_writelogic.sv
`default_nettype none
`timescale 1ns/1ps

module l1_cache_writelogic
(
    input  wire logic l2_read,
    input  lc3b_types::lc3b_mem_wmask mem_byte_enable,
    input  lc3b_types::lc3b_c_offset  offset,
    input  lc3b_types::lc3b_word      mem_wdata,
    input  lc3b_types::lc3b_cacheline l2_rdata,
    input  lc3b_types::lc3b_cacheline cur_cacheline,
    output lc3b_types::lc3b_cacheline output_cacheline
);

lc3b_types::lc3b_cacheline merged;

// Replace the enabled bytes of the addressed word.
always_comb begin
    merged = cur_cacheline;
    for (int w = 0; w < lc3b_types::L1_WORDS_PER_LINE; w++) begin
        if (w == int'(offset)) begin
            if (mem_byte_enable[0])
                merged[16*w +: 8] = mem_wdata[7:0];
            if (mem_byte_enable[1])
                merged[16*w + 8 +: 8] = mem_wdata[15:8];
        end
    end
end

// A fill takes the L2 line unchanged.
always_comb begin
    if (l2_read)
        output_cacheline = l2_rdata;
    else
        output_cacheline = merged;
end

endmodule : l1_cache_writelogic

`default_nettype wire

// File: src/l1_way.sv
`default_nettype none
`timescale 1ns/1ps

module l1_way
(
    input  wire logic clk,
    input  wire logic rst,

    input  wire logic load_d, load_v, load_td,
    input  wire logic d_in, v_in,
    input  lc3b_types::lc3b_c_index   index,
    input  lc3b_types::lc3b_c_tag     tag_in,
    input  lc3b_types::lc3b_cacheline data_in,

    output logic d_out, v_out,
    output lc3b_types::lc3b_c_tag     tag_out,
    output lc3b_types::lc3b_cacheline data_out
);

logic                      valid [lc3b_types::L1_SETS];
logic                      dirty [lc3b_types::L1_SETS];
lc3b_types::lc3b_c_tag     tags  [lc3b_types::L1_SETS];
lc3b_types::lc3b_cacheline lines [lc3b_types::L1_SETS];

// Status bits come out of reset cleared.
always_ff @(posedge clk) begin
    if (rst) begin
        for (int s = 0; s < lc3b_types::L1_SETS; s++) begin
            valid[s] <= 1'b0;
            dirty[s] <= 1'b0;
        end
    end else begin
        if (load_v)
            valid[index] <= v_in;
        if (load_d)
            dirty[index] <= d_in;
    end
end

// Tag and line are always written together.
always_ff @(posedge clk) begin
    if (load_td) begin
        tags[index]  <= tag_in;
        lines[index] <= data_in;
    end
end

// Reads are asynchronous at the current index.
assign v_out    = valid[index];
assign d_out    = dirty[index];
assign tag_out  = tags[index];
assign data_out = lines[index];

// A line must never be stored into an invalid set without marking it valid.
td_needs_valid: assert property (@(posedge clk) disable iff (rst)
    load_td |-> (load_v || valid[index]));

endmodule : l1_way

`default_nettype wire

// File: src/lc3b_types.sv
`default_nettype none

package lc3b_types;

    // ======================================================================
    // Cache geometry
    // ======================================================================
    localparam int L1_SETS           = 8;
    localparam int L1_WAYS           = 2;
    localparam int L1_WORDS_PER_LINE = 8;

    // ======================================================================
    // Data and address types
    // ======================================================================
    typedef logic [15:0]  lc3b_word;       // Data word or byte address.
    typedef logic [127:0] lc3b_cacheline;  // Word 0 sits in bits 15:0.
    typedef logic [8:0]   lc3b_c_tag;      // Address bits 15:7.
    typedef logic [2:0]   lc3b_c_index;    // Address bits 6:4.
    typedef logic [2:0]   lc3b_c_offset;   // Address bits 3:1.
    typedef logic [1:0]   lc3b_mem_wmask;  // Bit 0 enables the low byte.

    // Controller states.
    typedef enum logic [1:0] {
        s_check,
        s_writeback,
        s_fetch
    } l1_state;

    // Source of the L2 line address. The fourth code reads as zero.
    typedef enum logic [1:0] {
        addr_cpu  = 2'b00,
        addr_way0 = 2'b01,
        addr_way1 = 2'b10
    } l1_l2addr_src;

endpackage : lc3b_types

`default_nettype wire
